/* test/input_vectors.txt */
# game dip svc key prs tgl joy1 joy2 whl pulses exp_in0 exp_in1 exp_in2 exp_in3
# all columns hex, keyboard buttons stay held across lines until released
0 00 0 29 1 1 0000 0000 0 00 FF F7 00 00
0 00 0 76 1 1 0000 0000 0 00 FE F7 00 00
0 00 0 29 0 1 0000 0000 0 00 FE FF 00 00
0 00 0 76 0 1 0000 0000 0 00 FF FF 00 00
0 3C 1 00 0 0 0000 0000 0 00 7F FF 00 3C
0 00 0 22 1 1 0000 0000 0 00 EF FF 00 00
0 00 0 22 0 1 0000 0000 0 00 FF FF 00 00
1 00 0 00 0 0 0000 0010 0 00 FF FE 00 00
1 00 0 00 0 0 0000 0020 0 00 FF FD 00 00
1 00 0 00 0 0 0000 0040 0 00 FF FB 00 00
1 00 0 00 0 0 0000 0080 0 00 FF F7 00 00
1 00 0 00 0 0 0000 0100 0 00 FF EF 00 00
1 00 0 00 0 0 0000 0400 0 00 FE FF 00 00
1 00 0 00 0 0 0008 0000 0 03 FF FF 18 00
0 00 0 00 0 0 0001 0000 1 28 FF FF B0 00
0 00 0 00 0 0 0000 0000 1 02 FF FF A8 00
0 00 0 00 0 0 0002 0000 1 28 FF FF 30 00
2 00 0 00 0 0 0002 0000 0 02 FF FE FF 00
2 00 0 00 0 0 0008 0000 0 00 FF FE FB 00
2 00 0 00 0 0 0004 0000 0 00 FF FE F7 00
2 00 0 11 1 1 0000 0000 0 00 FF FE BF 00
2 00 0 29 1 1 0000 0000 0 00 FF FE AF 00
2 00 0 11 0 1 0000 0000 0 00 FF FE EF 00
2 5A 1 14 1 1 0000 0000 0 00 6F FE EF 5A
2 00 0 29 0 1 0000 0000 0 00 EF FE FF 00
2 00 0 14 0 1 0000 0000 0 00 FF FE FF 00
3 81 0 00 0 0 0000 0000 0 00 FF FF FF 81

/* tb.f */
hdl/mcr3_input_pkg.sv
hdl/player_ctrl_if.sv
hdl/control_decoder.sv
hdl/cabinet_config.sv
hdl/motion_emulator.sv
hdl/input_port_mapper.sv
hdl/mcr3_input_top.sv
test/tb_mcr3_input.sv

/* Bender.yml */
package:
  name: mcr3_input

sources:
  - files:
      - hdl/mcr3_input_pkg.sv
      - hdl/player_ctrl_if.sv
      - hdl/control_decoder.sv
      - hdl/cabinet_config.sv
      - hdl/motion_emulator.sv
      - hdl/input_port_mapper.sv
      - hdl/mcr3_input_top.sv
  - target: test
    files:
      - test/tb_mcr3_input.sv

/* test/tb_mcr3_input.sv */
`timescale 1ns/1ps

module tb_mcr3_input
	import mcr3_input_pkg::*;
;

	localparam int CLK_PERIOD = 100;
	localparam int MAX_VEC    = 64;
	localparam int N_FIELDS   = 14;

	logic             clk_sys;
	logic             rst_n;
	logic [3:0]       paddr;
	logic             psel;
	logic             penable;
	logic             pwrite;
	logic [7:0]       pwdata;
	logic [7:0]       prdata;
	logic             pready;
	logic             pslverr;
	logic [7:0]       key_code;
	logic             key_pressed;
	logic             key_toggle;
	logic [JOY_W-1:0] joy1;
	logic [JOY_W-1:0] joy2;
	logic             vsync;
	logic             wheel_select;
	logic [7:0]       input_0;
	logic [7:0]       input_1;
	logic [7:0]       input_2;
	logic [7:0]       input_3;

	// one row per vector line with fields in file order
	logic [15:0] vec_mem [0:MAX_VEC-1][0:N_FIELDS-1];
	int          n_vec;
	int          max_pulses;
	int          errors;
	int          checks;
	bit          wd_armed;
	longint      wd_limit;
	bit          load_ok;

	mcr3_input_top mcr3_input_top_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.key_code     (key_code),
		.key_pressed  (key_pressed),
		.key_toggle   (key_toggle),
		.joy1         (joy1),
		.joy2         (joy2),
		.vsync        (vsync),
		.wheel_select (wheel_select),
		.input_0      (input_0),
		.input_1      (input_1),
		.input_2      (input_2),
		.input_3      (input_3)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ==============================
	// helpers
	// ==============================
	task automatic compare_byte(input string name, input string ctx, input logic [7:0] exp,
		input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s (%s): expected %02h, actual %02h", name, ctx, exp, act);
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk_sys);
		penable <= 1'b1; // write lands on the edge that ends the access phase
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [7:0] data, output logic err);
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(negedge clk_sys);
		data = prdata;
		err  = pslverr;
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic expect_reg(input logic [3:0] addr, input logic [7:0] exp, input string ctx);
		logic [7:0] rd;
		logic       err;
		read_reg(addr, rd, err);
		compare_byte("prdata", ctx, exp, rd);
		compare_byte("pslverr", ctx, 8'h00, {7'b0000000, err});
	endtask

	task automatic pulse_vsync();
		@(posedge clk_sys);
		vsync <= 1'b1;
		repeat (4) @(posedge clk_sys);
		vsync <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic load_vectors(output bit ok);
		int    fd;
		int    n;
		int    fld [N_FIELDS];
		string line;
		ok         = 1'b0;
		n_vec      = 0;
		max_pulses = 0;
		fd = $fopen("test/input_vectors.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && n_vec < MAX_VEC) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
						fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
					if (n == N_FIELDS) begin
						for (int i = 0; i < N_FIELDS; i++)
							vec_mem[n_vec][i] = 16'(fld[i]);
						if (fld[9] > max_pulses)
							max_pulses = fld[9];
						n_vec++;
					end
				end
			end
			$fclose(fd);
			ok = (n_vec > 0);
		end
	endtask

	// ==============================
	// directed register checks
	// ==============================
	task automatic check_registers();
		logic [7:0] rd;
		logic       err;
		expect_reg(REG_GAME, 8'h00, "game after reset");
		expect_reg(REG_DIP, 8'h00, "dip after reset");
		expect_reg(REG_CTRL, 8'h00, "ctrl after reset");
		write_reg(REG_GAME, 8'hFE); // only bits 1:0 kept
		write_reg(REG_DIP, 8'hA5);
		write_reg(REG_CTRL, 8'hFF);
		expect_reg(REG_GAME, 8'h02, "game readback");
		expect_reg(REG_DIP, 8'hA5, "dip readback");
		expect_reg(REG_CTRL, 8'h01, "ctrl readback");
		read_reg(4'hC, rd, err);
		compare_byte("prdata", "read offset c", 8'h00, rd);
		compare_byte("pslverr", "read offset c", 8'h01, {7'b0000000, err});
		write_reg(4'hC, 8'h00);
		expect_reg(REG_GAME, 8'h02, "game after bad write");
		expect_reg(REG_DIP, 8'hA5, "dip after bad write");
		expect_reg(REG_CTRL, 8'h01, "ctrl after bad write");
		@(negedge clk_sys);
		compare_byte("input_3", "dip write", 8'hA5, input_3);
	endtask

	task automatic apply_step(input int idx);
		int    gap;
		string ctx;
		write_reg(REG_GAME, vec_mem[idx][0][7:0]);
		write_reg(REG_DIP, vec_mem[idx][1][7:0]);
		write_reg(REG_CTRL, vec_mem[idx][2][7:0]);
		@(posedge clk_sys);
		key_code     <= vec_mem[idx][3][7:0];
		key_pressed  <= vec_mem[idx][4][0];
		if (vec_mem[idx][5][0])
			key_toggle <= ~key_toggle; // level change is the event
		joy1         <= vec_mem[idx][6];
		joy2         <= vec_mem[idx][7];
		wheel_select <= vec_mem[idx][8][0];
		repeat (vec_mem[idx][9]) pulse_vsync();
		gap = 4 + ($urandom % 4);
		repeat (gap) @(posedge clk_sys);
		@(negedge clk_sys);
		ctx = $sformatf("step %0d", idx);
		compare_byte("input_0", ctx, vec_mem[idx][10][7:0], input_0);
		compare_byte("input_1", ctx, vec_mem[idx][11][7:0], input_1);
		compare_byte("input_2", ctx, vec_mem[idx][12][7:0], input_2);
		compare_byte("input_3", ctx, vec_mem[idx][13][7:0], input_3);
	endtask

	// watchdog armed once the vector count is known
	initial begin
		wait (wd_armed);
		#(wd_limit);
		$display("watchdog expired before the test sequence finished");
		$display("TESTS FAILED");
		$finish;
	end

	// ==============================
	// main sequence
	// ==============================
	initial begin
		rst_n        = 1'b0;
		paddr        = 4'h0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = 8'h00;
		key_code     = 8'h00;
		key_pressed  = 1'b0;
		key_toggle   = 1'b0;
		joy1         = '0;
		joy2         = '0;
		vsync        = 1'b0;
		wheel_select = 1'b0;
		errors       = 0;
		checks       = 0;
		wd_armed     = 1'b0;
		void'($urandom(32'h5de8));
		load_vectors(load_ok);
		if (!load_ok) begin
			$display("could not read any vectors from test/input_vectors.txt");
			$display("TESTS FAILED");
			$finish;
		end else begin
			// each step takes 3 apb writes plus 8 cycles per pulse plus the gap and slack
			wd_limit = (longint'(n_vec) * (max_pulses * 8 + 20) + 200) * CLK_PERIOD;
			wd_armed = 1'b1;
			repeat (3) @(posedge clk_sys);
			rst_n <= 1'b1;
			@(negedge clk_sys);
			compare_byte("input_0", "reset", 8'hFF, input_0);
			compare_byte("input_1", "reset", 8'hFF, input_1);
			compare_byte("input_2", "reset", 8'h00, input_2);
			compare_byte("input_3", "reset", 8'h00, input_3);
			compare_byte("pready", "reset", 8'h01, {7'b0000000, pready});
			check_registers();
			for (int i = 0; i < n_vec; i++)
				apply_step(i);
			$display("checks: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("TESTS PASSED");
			else
				$display("TESTS FAILED");
			$finish;
		end
	end

endmodule

/* hdl/mcr3_input_top.sv */
`timescale 1ns/1ps

module mcr3_input_top
	import mcr3_input_pkg::*;
#(
	parameter int unsigned STEER_STEP = 4,
	parameter int unsigned GAS_STEP   = 8
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	// apb config port
	input  logic [3:0]       paddr,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  logic [7:0]       pwdata,
	output logic [7:0]       prdata,
	output logic             pready,
	output logic             pslverr,
	// ps/2 key event
	input  logic [7:0]       key_code,
	input  logic             key_pressed,
	input  logic             key_toggle,
	input  logic [JOY_W-1:0] joy1,
	input  logic [JOY_W-1:0] joy2,
	input  logic             vsync,
	input  logic             wheel_select,
	// game input ports
	output logic [7:0]       input_0,
	output logic [7:0]       input_1,
	output logic [7:0]       input_2,
	output logic [7:0]       input_3
);

	game_e      game;
	logic [7:0] dip;
	logic       service;
	logic [7:0] steering;
	logic [7:0] gas;
	logic [7:0] spin_angle;

	player_ctrl_if player_ctrl ();

	// ==============================
	// instances
	// ==============================
	control_decoder control_decoder_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.key_toggle  (key_toggle),
		.joy1        (joy1),
		.joy2        (joy2),
		.ctrl        (player_ctrl.source)
	);

	cabinet_config cabinet_config_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.game    (game),
		.dip     (dip),
		.service (service)
	);

	motion_emulator #(
		.STEER_STEP (STEER_STEP),
		.GAS_STEP   (GAS_STEP)
	) motion_emulator_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.vsync      (vsync),
		.ctrl       (player_ctrl.sink),
		.steering   (steering),
		.gas        (gas),
		.spin_angle (spin_angle)
	);

	input_port_mapper input_port_mapper_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ctrl         (player_ctrl.sink),
		.game         (game),
		.dip          (dip),
		.service      (service),
		.steering     (steering),
		.gas          (gas),
		.spin_angle   (spin_angle),
		.wheel_select (wheel_select),
		.input_0      (input_0),
		.input_1      (input_1),
		.input_2      (input_2),
		.input_3      (input_3)
	);

endmodule

/* hdl/input_port_mapper.sv */
`timescale 1ns/1ps

module input_port_mapper
	import mcr3_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	player_ctrl_if.sink ctrl,
	input  game_e       game,
	input  logic [7:0]  dip,
	input  logic        service,
	input  logic [7:0]  steering,
	input  logic [7:0]  gas,
	input  logic [7:0]  spin_angle,
	input  logic        wheel_select,
	output logic [7:0]  input_0,
	output logic [7:0]  input_1,
	output logic [7:0]  input_2,
	output logic [7:0]  input_3
);

	logic [7:0] drive_in0;  // shared by both driving games
	logic [7:0] drive_in2;
	logic [7:0] byte0_next;
	logic [7:0] byte1_next;
	logic [7:0] byte2_next;

	assign drive_in0 = ~{service, 2'b00, ctrl.shift, 3'b000, ctrl.coin};
	assign drive_in2 = wheel_select ? steering : gas; // latch bit picks wheel or pedal

	// ==============================
	// per-game byte layout, active low
	// ==============================
	always_comb begin
		byte0_next = 8'hFF;
		byte1_next = 8'hFF;
		byte2_next = 8'hFF;
		case (game)
			GAME_SPYHUNT: begin
				byte0_next = drive_in0;
				byte1_next = ~{3'b000, ctrl.fire_a, ctrl.fire_c, ctrl.fire_e,
					ctrl.fire_b, ctrl.fire_d};
				byte2_next = drive_in2;
			end
			GAME_TURBO: begin
				byte0_next = drive_in0;
				byte1_next = ~{3'b000, ctrl.fire_e, ctrl.fire_d, ctrl.fire_c,
					ctrl.fire_b, ctrl.fire_a};
				byte2_next = drive_in2;
			end
			GAME_CRATER: begin
				byte0_next = ~{service, 2'b00, ctrl.fire_a, ctrl.fire_e, ctrl.shift,
					1'b0, ctrl.coin};
				byte1_next = spin_angle;
				byte2_next = ~{1'b0, ctrl.fire_b, 1'b0, ctrl.fire_c, ctrl.down, ctrl.up, 2'b00};
			end
			default: ; // no game, all released
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			input_0 <= 8'hFF;
			input_1 <= 8'hFF;
			input_2 <= 8'h00;
			input_3 <= 8'h00;
		end else begin
			input_0 <= byte0_next;
			input_1 <= byte1_next;
			input_2 <= byte2_next;
			input_3 <= dip; // dip bank 0 for every game
		end
	end

endmodule

/* hdl/motion_emulator.sv */
`timescale 1ns/1ps

module motion_emulator
	import mcr3_input_pkg::*;
#(
	parameter int unsigned STEER_STEP = 4,
	parameter int unsigned GAS_STEP   = 8
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        vsync,
	player_ctrl_if.sink ctrl,
	output logic [7:0]  steering,
	output logic [7:0]  gas,
	output logic [7:0]  spin_angle
);

	localparam logic [8:0] STEER_STEP_W = 9'(STEER_STEP);
	localparam logic [8:0] GAS_STEP_W   = 9'(GAS_STEP);

	logic       vsync_q;
	logic       vsync_prev;
	logic       frame_stb;
	logic [8:0] steer_inc;
	logic [8:0] steer_dec;
	logic [8:0] gas_inc;
	logic [8:0] gas_dec;
	logic [7:0] steer_next;
	logic [7:0] gas_next;
	logic [7:0] spin_next;
	logic       spin_cw;
	logic       spin_ccw;

	// ==============================
	// frame strobe from vsync rise
	// ==============================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vsync_q    <= 1'b0;
			vsync_prev <= 1'b0;
		end else begin
			vsync_q    <= vsync;
			vsync_prev <= vsync_q;
		end
	end

	assign frame_stb = vsync_q & ~vsync_prev;

	assign steer_inc = {1'b0, steering} + STEER_STEP_W;
	assign steer_dec = {1'b0, steering} - STEER_STEP_W;
	assign gas_inc   = {1'b0, gas} + GAS_STEP_W;
	assign gas_dec   = {1'b0, gas} - GAS_STEP_W;
	assign spin_cw   = ctrl.right | ctrl.spin_cw;
	assign spin_ccw  = ctrl.left | ctrl.spin_ccw;

	always_comb begin
		// steering, self-centers when no single direction held
		if (ctrl.right && !ctrl.left)
			steer_next = (steer_inc > {1'b0, STEER_MAX}) ? STEER_MAX : steer_inc[7:0];
		else if (ctrl.left && !ctrl.right)
			steer_next = ({1'b0, steering} < {1'b0, STEER_MIN} + STEER_STEP_W) ?
				STEER_MIN : steer_dec[7:0];
		else if (steering > STEER_CENTER)
			steer_next = ({1'b0, steering} < {1'b0, STEER_CENTER} + STEER_STEP_W) ?
				STEER_CENTER : steer_dec[7:0];
		else
			steer_next = (steer_inc > {1'b0, STEER_CENTER}) ? STEER_CENTER : steer_inc[7:0];

		// gas pedal holds when idle
		if (ctrl.up && !ctrl.down)
			gas_next = (gas_inc > 9'h0FF) ? 8'hFF : gas_inc[7:0];
		else if (ctrl.down && !ctrl.up)
			gas_next = ({1'b0, gas} < GAS_STEP_W) ? 8'h00 : gas_dec[7:0];
		else
			gas_next = gas;

		if (spin_cw && !spin_ccw)
			spin_next = spin_angle + 8'd1; // wraps
		else if (spin_ccw && !spin_cw)
			spin_next = spin_angle - 8'd1;
		else
			spin_next = spin_angle;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			steering   <= STEER_CENTER;
			gas        <= 8'h00;
			spin_angle <= 8'h00;
		end else if (frame_stb) begin
			steering   <= steer_next;
			gas        <= gas_next;
			spin_angle <= spin_next;
		end
	end

endmodule

/* hdl/cabinet_config.sv */
`timescale 1ns/1ps

module cabinet_config
	import mcr3_input_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [3:0] paddr,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic       pready,
	output logic       pslverr,
	output game_e      game,
	output logic [7:0] dip,
	output logic       service
);

	cfg_reg_e reg_sel;
	logic     addr_hit;
	logic     access;
	logic     wr_en;

	assign reg_sel = cfg_reg_e'(paddr);
	assign access  = psel & penable;
	assign wr_en   = access & pwrite & addr_hit;

	// ==============================
	// decode and read mux
	// ==============================
	always_comb begin
		addr_hit = 1'b1;
		prdata   = 8'h00;
		case (reg_sel)
			REG_GAME: prdata = {6'b000000, game};
			REG_DIP:  prdata = dip;
			REG_CTRL: prdata = {7'b0000000, service};
			default:  addr_hit = 1'b0;
		endcase
	end

	assign pready  = 1'b1; // zero wait states
	assign pslverr = access & ~addr_hit;

	// register writes at the access phase edge
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			game    <= GAME_SPYHUNT;
			dip     <= 8'h00;
			service <= 1'b0;
		end else if (wr_en) begin
			case (reg_sel)
				REG_GAME: game    <= game_e'(pwdata[1:0]); // upper bits dropped
				REG_DIP:  dip     <= pwdata;
				REG_CTRL: service <= pwdata[0];
				default:  ;
			endcase
		end
	end

endmodule

/* hdl/control_decoder.sv */
`timescale 1ns/1ps

module control_decoder
	import mcr3_input_pkg::*;
(
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [7:0]       key_code,
	input  logic             key_pressed,
	input  logic             key_toggle,
	input  logic [JOY_W-1:0] joy1,
	input  logic [JOY_W-1:0] joy2,
	player_ctrl_if.source    ctrl
);

	key_code_e code_q;
	logic      pressed_q;
	logic      toggle_q;
	logic      toggle_prev;
	logic      key_event;

	// held keyboard buttons
	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_fire_a;
	logic btn_fire_b;
	logic btn_fire_c;
	logic btn_fire_d;
	logic btn_fire_e;
	logic btn_shift;
	logic btn_coin1;
	logic btn_coin2;

	// ==============================
	// key event capture
	// ==============================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			toggle_q    <= 1'b0;
			toggle_prev <= 1'b0;
		end else begin
			toggle_q    <= key_toggle;
			toggle_prev <= toggle_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		code_q    <= key_code_e'(key_code); // kept aligned with toggle_q
		pressed_q <= key_pressed;
	end

	assign key_event = toggle_q ^ toggle_prev; // any level change is one event

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_fire_a <= 1'b0;
			btn_fire_b <= 1'b0;
			btn_fire_c <= 1'b0;
			btn_fire_d <= 1'b0;
			btn_fire_e <= 1'b0;
			btn_shift  <= 1'b0;
			btn_coin1  <= 1'b0;
			btn_coin2  <= 1'b0;
		end else if (key_event) begin
			case (code_q)
				KEY_UP:        btn_up     <= pressed_q;
				KEY_DOWN:      btn_down   <= pressed_q;
				KEY_LEFT:      btn_left   <= pressed_q;
				KEY_RIGHT:     btn_right  <= pressed_q;
				KEY_FIRE_A:    btn_fire_a <= pressed_q;
				KEY_FIRE_B:    btn_fire_b <= pressed_q;
				KEY_FIRE_C:    btn_fire_c <= pressed_q;
				KEY_FIRE_D:    btn_fire_d <= pressed_q;
				KEY_FIRE_E:    btn_fire_e <= pressed_q;
				KEY_SHIFT:     btn_shift  <= pressed_q;
				KEY_COIN1:     btn_coin1  <= pressed_q;
				KEY_COIN1_ALT: btn_coin1  <= pressed_q; // mame style coin
				KEY_COIN2:     btn_coin2  <= pressed_q;
				default:       ; // other keys ignored
			endcase
		end
	end

	// keyboard or either stick
	assign ctrl.up       = btn_up     | joy1[JOY_UP]     | joy2[JOY_UP];
	assign ctrl.down     = btn_down   | joy1[JOY_DOWN]   | joy2[JOY_DOWN];
	assign ctrl.left     = btn_left   | joy1[JOY_LEFT]   | joy2[JOY_LEFT];
	assign ctrl.right    = btn_right  | joy1[JOY_RIGHT]  | joy2[JOY_RIGHT];
	assign ctrl.fire_a   = btn_fire_a | joy1[JOY_FIRE_A] | joy2[JOY_FIRE_A];
	assign ctrl.fire_b   = btn_fire_b | joy1[JOY_FIRE_B] | joy2[JOY_FIRE_B];
	assign ctrl.fire_c   = btn_fire_c | joy1[JOY_FIRE_C] | joy2[JOY_FIRE_C];
	assign ctrl.fire_d   = btn_fire_d | joy1[JOY_FIRE_D] | joy2[JOY_FIRE_D];
	assign ctrl.fire_e   = btn_fire_e | joy1[JOY_FIRE_E] | joy2[JOY_FIRE_E];
	assign ctrl.shift    = btn_shift  | joy1[JOY_SHIFT]  | joy2[JOY_SHIFT];
	assign ctrl.coin     = btn_coin1  | btn_coin2 | joy1[JOY_COIN] | joy2[JOY_COIN];
	assign ctrl.spin_ccw = joy1[JOY_SPIN_CCW] | joy2[JOY_SPIN_CCW]; // no key for spinner
	assign ctrl.spin_cw  = joy1[JOY_SPIN_CW]  | joy2[JOY_SPIN_CW];

endmodule

/* hdl/player_ctrl_if.sv */
`timescale 1ns/1ps

// merged player controls, plain levels
interface player_ctrl_if;
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire_a;
	logic fire_b;
	logic fire_c;
	logic fire_d;
	logic fire_e;
	logic shift;
	logic coin;
	logic spin_ccw;
	logic spin_cw;

	modport source (output up, down, left, right, fire_a, fire_b, fire_c, fire_d, fire_e,
		shift, coin, spin_ccw, spin_cw);
	modport sink (input up, down, left, right, fire_a, fire_b, fire_c, fire_d, fire_e,
		shift, coin, spin_ccw, spin_cw);
endinterface

/* hdl/mcr3_input_pkg.sv */
package mcr3_input_pkg;

	// ==============================
	// game select, 3 reads as no game
	// ==============================
	typedef enum logic [1:0] {
		GAME_SPYHUNT = 2'd0,
		GAME_TURBO   = 2'd1,
		GAME_CRATER  = 2'd2
	} game_e;

	// ps/2 set-2 make codes
	typedef enum logic [7:0] {
		KEY_UP        = 8'h75,
		KEY_DOWN      = 8'h72,
		KEY_LEFT      = 8'h6B,
		KEY_RIGHT     = 8'h74,
		KEY_COIN1     = 8'h76, // esc
		KEY_COIN1_ALT = 8'h2E, // 5
		KEY_COIN2     = 8'h36, // 6
		KEY_FIRE_A    = 8'h14, // l-ctrl
		KEY_FIRE_B    = 8'h11, // alt
		KEY_FIRE_C    = 8'h29, // space
		KEY_FIRE_D    = 8'h12, // l-shift
		KEY_FIRE_E    = 8'h1A, // z
		KEY_SHIFT     = 8'h22  // x
	} key_code_e;

	// apb register offsets
	typedef enum logic [3:0] {
		REG_GAME = 4'h0,
		REG_DIP  = 4'h4,
		REG_CTRL = 4'h8 // bit 0 service
	} cfg_reg_e;

	// ==============================
	// joystick word bit map
	// ==============================
	localparam int JOY_W        = 16;
	localparam int JOY_RIGHT    = 0;
	localparam int JOY_LEFT     = 1;
	localparam int JOY_DOWN     = 2;
	localparam int JOY_UP       = 3;
	localparam int JOY_FIRE_A   = 4;
	localparam int JOY_FIRE_B   = 5;
	localparam int JOY_FIRE_C   = 6;
	localparam int JOY_FIRE_D   = 7;
	localparam int JOY_FIRE_E   = 8;
	localparam int JOY_SHIFT    = 9;
	localparam int JOY_COIN     = 10;
	localparam int JOY_SPIN_CCW = 14;
	localparam int JOY_SPIN_CW  = 15;

	// wheel range
	localparam logic [7:0] STEER_CENTER = 8'h70;
	localparam logic [7:0] STEER_MIN    = 8'h30;
	localparam logic [7:0] STEER_MAX    = 8'hB0;

endpackage
